// File: gat_macros.svh
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// Layer dimensions
`define GAT_FEAT_IN          8
`define GAT_FEAT_OUT         4

// Datapath widths
`define GAT_DATA_W           8
`define GAT_COL_W            3
`define GAT_WH_W             20
`define GAT_COEF_W           32

// W rows followed by both halves of a
`define GAT_WGT_DEPTH        40
`define GAT_WGT_ADDR_W       6

// Queue depths
`define GAT_WH_FIFO_DEPTH    8
`define GAT_COEF_FIFO_DEPTH  16

`endif

// File: gat_pkg.sv
`include "gat_macros.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic        [`GAT_COL_W-1:0]  col_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  typedef wh_t   [`GAT_FEAT_OUT-1:0]     wh_vec_t;
  typedef data_t [`GAT_FEAT_OUT-1:0]     w_row_t;
  // Low half is source, high half is destination
  typedef data_t [2*`GAT_FEAT_OUT-1:0]   a_vec_t;

  typedef struct packed {
    wh_vec_t wh;
    logic    last;
  } wh_entry_t;

  typedef struct packed {
    coef_t coef;
    logic  last;
  } coef_entry_t;

endpackage

// File: gat_weight_bank.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_weight_bank (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wgt_wr_i,
  input  logic [`GAT_WGT_ADDR_W-1:0] wgt_addr_i,
  input  gat_pkg::data_t             wgt_data_i,
  input  logic                       wgt_done_i,
  input  gat_pkg::col_t              w_col_i,
  output gat_pkg::w_row_t            w_row_o,
  output gat_pkg::a_vec_t            a_vec_o,
  output logic                       ready_o
);

  // a follows the full W matrix
  localparam int A_BASE = `GAT_FEAT_IN * `GAT_FEAT_OUT;

  gat_pkg::data_t mem [`GAT_WGT_DEPTH];

  always_ff @(posedge clk) begin
    if (wgt_wr_i && (int'(wgt_addr_i) < `GAT_WGT_DEPTH)) begin
      mem[wgt_addr_i] <= wgt_data_i;
    end
  end

  // Row-major W, one input feature per row
  always_comb begin
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      w_row_o[j] = mem[int'(w_col_i) * `GAT_FEAT_OUT + j];
    end
    for (int k = 0; k < 2 * `GAT_FEAT_OUT; k++) begin
      a_vec_o[k] = mem[A_BASE + k];
    end
  end

  // Stays up until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_o <= 1'b0;
    end else if (wgt_done_i) begin
      ready_o <= 1'b1;
    end
  end

  a_wr_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wgt_wr_i |-> (int'(wgt_addr_i) < `GAT_WGT_DEPTH)
  ) else $error("weight write beyond bank at address %0d", wgt_addr_i);

endmodule

// File: gat_fifo.sv
`timescale 1ns/10ps

module gat_fifo #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_i,
  input  payload_t                   din_i,
  input  logic                       rd_i,
  output payload_t                   dout_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             wr_en;
  logic             rd_en;

  assign wr_en   = wr_i && !full_o;
  assign rd_en   = rd_i && !empty_o;
  assign empty_o = (count_o == '0);
  assign full_o  = (count_o == CNT_W'(DEPTH));

  // Show-ahead head entry
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_i |-> !full_o)
    else $error("write into full FIFO, entry lost");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_i |-> !empty_o)
    else $error("read from empty FIFO");

endmodule

// File: gat_wh_accum.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_wh_accum (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en_i,
  input  logic               h_vld_i,
  input  logic               h_row_last_i,
  input  logic               h_sub_last_i,
  input  gat_pkg::col_t      h_col_i,
  input  gat_pkg::data_t     h_val_i,
  output gat_pkg::col_t      w_col_o,
  input  gat_pkg::w_row_t    w_row_i,
  output logic               wh_vld_o,
  output gat_pkg::wh_entry_t wh_entry_o
);

  logic             accept;
  logic             row_done;
  gat_pkg::wh_vec_t acc;
  gat_pkg::wh_vec_t acc_next;

  // Strobes before the weights are loaded are dropped
  assign accept   = en_i && h_vld_i;
  assign row_done = accept && h_row_last_i;

  // W row addressed by the nonzero's column
  assign w_col_o = h_col_i;

  always_comb begin
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      acc_next[j] = acc[j] + gat_pkg::wh_t'(h_val_i * w_row_i[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc      <= '0;
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= row_done;
      if (accept) begin
        // Restart from zero for the next node row
        acc <= h_row_last_i ? '0 : acc_next;
      end
    end
  end

  // Finished row with its subgraph flag
  always_ff @(posedge clk) begin
    if (row_done) begin
      wh_entry_o.wh   <= acc_next;
      wh_entry_o.last <= h_sub_last_i;
    end
  end

endmodule

// File: gat_coef_calc.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_coef_calc (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        wh_empty_i,
  input  gat_pkg::wh_entry_t                          wh_entry_i,
  output logic                                        wh_rd_o,
  input  gat_pkg::a_vec_t                             a_vec_i,
  input  logic [$clog2(`GAT_COEF_FIFO_DEPTH+1)-1:0]   coef_count_i,
  output logic                                        coef_wr_o,
  output gat_pkg::coef_entry_t                        coef_entry_o
);

  localparam int HALF  = `GAT_FEAT_OUT;
  localparam int CNT_W = $clog2(`GAT_COEF_FIFO_DEPTH + 1);
  localparam int SUM_W = CNT_W + 1;

  logic             first_q;
  logic             s1_vld;
  logic             s1_last;
  gat_pkg::coef_t   s1_prod [HALF];
  gat_pkg::coef_t   src_term;
  gat_pkg::coef_t   src_dot;
  gat_pkg::coef_t   coef_sum;
  logic [SUM_W-1:0] pending;

  // Queued entries plus the ones still in the pipeline
  assign pending = SUM_W'(coef_count_i) + SUM_W'(s1_vld) + SUM_W'(coef_wr_o);
  assign wh_rd_o = !wh_empty_i && (pending < SUM_W'(`GAT_COEF_FIFO_DEPTH));

  // Source half of a against the popped row, kept only for a target
  always_comb begin
    src_dot = '0;
    for (int k = 0; k < HALF; k++) begin
      src_dot = src_dot + a_vec_i[k] * wh_entry_i.wh[k];
    end
  end

  always_comb begin
    coef_sum = src_term;
    for (int k = 0; k < HALF; k++) begin
      coef_sum = coef_sum + s1_prod[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q   <= 1'b1;
      s1_vld    <= 1'b0;
      coef_wr_o <= 1'b0;
    end else begin
      s1_vld    <= wh_rd_o;
      coef_wr_o <= s1_vld;
      if (wh_rd_o) begin
        // Row after a subgraph end is the next target
        first_q <= wh_entry_i.last;
      end
    end
  end

  // Stage one, destination-half products
  always_ff @(posedge clk) begin
    if (wh_rd_o) begin
      for (int k = 0; k < HALF; k++) begin
        s1_prod[k] <= a_vec_i[HALF + k] * wh_entry_i.wh[k];
      end
      s1_last <= wh_entry_i.last;
      if (first_q) begin
        src_term <= src_dot;
      end
    end
  end

  // Stage two, full-precision sum
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      coef_entry_o.coef <= coef_sum;
      coef_entry_o.last <= s1_last;
    end
  end

  // Room reserved at pop time must still be there at the write
  a_coef_room: assert property (
    @(posedge clk) disable iff (!rst_n)
    coef_wr_o |-> (coef_count_i < CNT_W'(`GAT_COEF_FIFO_DEPTH))
  ) else $error("coefficient written with no room reserved");

endmodule

// File: gat_conv_top.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_conv_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wgt_wr_i,
  input  logic [`GAT_WGT_ADDR_W-1:0] wgt_addr_i,
  input  gat_pkg::data_t             wgt_data_i,
  input  logic                       wgt_done_i,
  input  logic                       h_vld_i,
  input  gat_pkg::col_t              h_col_i,
  input  gat_pkg::data_t             h_val_i,
  input  logic                       h_row_last_i,
  input  logic                       h_sub_last_i,
  output logic                       gat_ready_o,
  output logic                       wh_vld_o,
  output gat_pkg::wh_vec_t           wh_o,
  input  logic                       coef_rd_i,
  output gat_pkg::coef_t             coef_o,
  output logic                       coef_last_o,
  output logic                       coef_empty_o
);

  gat_pkg::col_t        w_col;
  gat_pkg::w_row_t      w_row;
  gat_pkg::a_vec_t      a_vec;
  gat_pkg::wh_entry_t   wh_entry;
  gat_pkg::wh_entry_t   wh_head;
  logic                 wh_empty;
  logic                 wh_rd;
  logic                 coef_wr;
  gat_pkg::coef_entry_t coef_entry;
  gat_pkg::coef_entry_t coef_head;
  logic [$clog2(`GAT_COEF_FIFO_DEPTH+1)-1:0] coef_count;

  assign wh_o        = wh_entry.wh;
  assign coef_o      = coef_head.coef;
  assign coef_last_o = coef_head.last;

  gat_weight_bank u_weight_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_wr_i   (wgt_wr_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .wgt_done_i (wgt_done_i),
    .w_col_i    (w_col),
    .w_row_o    (w_row),
    .a_vec_o    (a_vec),
    .ready_o    (gat_ready_o)
  );

  gat_wh_accum u_wh_accum (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (gat_ready_o),
    .h_vld_i      (h_vld_i),
    .h_row_last_i (h_row_last_i),
    .h_sub_last_i (h_sub_last_i),
    .h_col_i      (h_col_i),
    .h_val_i      (h_val_i),
    .w_col_o      (w_col),
    .w_row_i      (w_row),
    .wh_vld_o     (wh_vld_o),
    .wh_entry_o   (wh_entry)
  );

  gat_fifo #(
    .DEPTH     (`GAT_WH_FIFO_DEPTH),
    .payload_t (gat_pkg::wh_entry_t)
  ) u_wh_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (wh_vld_o),
    .din_i   (wh_entry),
    .rd_i    (wh_rd),
    .dout_o  (wh_head),
    .empty_o (wh_empty),
    .full_o  (),
    .count_o ()
  );

  gat_coef_calc u_coef_calc (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_empty_i   (wh_empty),
    .wh_entry_i   (wh_head),
    .wh_rd_o      (wh_rd),
    .a_vec_i      (a_vec),
    .coef_count_i (coef_count),
    .coef_wr_o    (coef_wr),
    .coef_entry_o (coef_entry)
  );

  gat_fifo #(
    .DEPTH     (`GAT_COEF_FIFO_DEPTH),
    .payload_t (gat_pkg::coef_entry_t)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (coef_wr),
    .din_i   (coef_entry),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_head),
    .empty_o (coef_empty_o),
    .full_o  (),
    .count_o (coef_count)
  );

endmodule

// File: tb_gat_conv.sv
`timescale 1ns/10ps
`include "gat_macros.svh"

module tb_gat_conv;

  localparam int MAX_NZ   = 64;
  localparam int MAX_ROWS = 16;
  localparam int A_BASE   = `GAT_FEAT_IN * `GAT_FEAT_OUT;

  logic                       clk;
  logic                       rst_n;
  logic                       wgt_wr;
  logic [`GAT_WGT_ADDR_W-1:0] wgt_addr;
  gat_pkg::data_t             wgt_data;
  logic                       wgt_done;
  logic                       h_vld;
  gat_pkg::col_t              h_col;
  gat_pkg::data_t             h_val;
  logic                       h_row_last;
  logic                       h_sub_last;
  logic                       gat_ready;
  logic                       wh_vld;
  gat_pkg::wh_vec_t           wh;
  logic                       coef_rd;
  gat_pkg::coef_t             coef;
  logic                       coef_last;
  logic                       coef_empty;

  int               wgt [`GAT_WGT_DEPTH];
  int               nz_col [MAX_NZ];
  int               nz_val [MAX_NZ];
  int               nz_rl [MAX_NZ];
  int               nz_sl [MAX_NZ];
  gat_pkg::wh_vec_t file_wh [MAX_ROWS];
  gat_pkg::coef_t   file_coef [MAX_ROWS];
  logic             file_last [MAX_ROWS];
  int               n_nz = 0;
  int               n_rows = 0;
  gat_pkg::wh_vec_t wh_exp_q [$];
  int               wh_cyc_q [$];
  int               wh_idx = 0;
  int               fd;
  int               errors = 0;
  int               tests = 0;
  int               failed_tests = 0;
  int               cycle = 0;
  int               limit = 0;

  gat_conv_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_wr_i     (wgt_wr),
    .wgt_addr_i   (wgt_addr),
    .wgt_data_i   (wgt_data),
    .wgt_done_i   (wgt_done),
    .h_vld_i      (h_vld),
    .h_col_i      (h_col),
    .h_val_i      (h_val),
    .h_row_last_i (h_row_last),
    .h_sub_last_i (h_sub_last),
    .gat_ready_o  (gat_ready),
    .wh_vld_o     (wh_vld),
    .wh_o         (wh),
    .coef_rd_i    (coef_rd),
    .coef_o       (coef),
    .coef_last_o  (coef_last),
    .coef_empty_o (coef_empty)
  );

  always #20 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout: run stopped at cycle %0d before all results arrived", cycle);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  function automatic string wh_str(input gat_pkg::wh_vec_t v);
    string s;
    s = "[";
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      s = {s, $sformatf(" %0d", $signed(v[j]))};
    end
    return {s, " ]"};
  endfunction

  task automatic check_wh(input string name, input gat_pkg::wh_vec_t exp_v,
                          input gat_pkg::wh_vec_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %s actual %s", name, wh_str(exp_v), wh_str(act_v));
    end
  endtask

  task automatic check_coef(input string name, input gat_pkg::coef_t exp_v,
                            input gat_pkg::coef_t act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %0d actual %0d", name, exp_v, act_v);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      errors++;
      $display("FAIL %s expected %b actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      failed_tests++;
      $display("%s failed", name);
    end
  endtask

  task automatic read_int(output int v);
    int rc;
    rc = $fscanf(fd, "%d", v);
    if (rc != 1) begin
      report_error("stimulus file ended early or holds a bad field");
      v = 0;
    end
  endtask

  task automatic read_stimulus();
    string line;
    int x;
    fd = $fopen("gat_stimulus.txt", "r");
    if (fd == 0) begin
      report_error("cannot open gat_stimulus.txt");
    end else begin
      // Two column description lines
      void'($fgets(line, fd));
      void'($fgets(line, fd));
      for (int i = 0; i < `GAT_WGT_DEPTH; i++) begin
        read_int(wgt[i]);
      end
      read_int(n_nz);
      if (n_nz > MAX_NZ || n_nz < 0) begin
        report_error("nonzero count in the stimulus file is out of range");
        n_nz = 0;
      end
      for (int n = 0; n < n_nz; n++) begin
        read_int(nz_col[n]);
        read_int(nz_val[n]);
        read_int(nz_rl[n]);
        read_int(nz_sl[n]);
      end
      read_int(n_rows);
      if (n_rows > MAX_ROWS || n_rows < 0) begin
        report_error("row count in the stimulus file is out of range");
        n_rows = 0;
      end
      for (int r = 0; r < n_rows; r++) begin
        for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
          read_int(x);
          file_wh[r][j] = gat_pkg::wh_t'(x);
        end
      end
      for (int r = 0; r < n_rows; r++) begin
        read_int(x);
        file_coef[r] = gat_pkg::coef_t'(x);
        read_int(x);
        file_last[r] = x[0];
      end
      $fclose(fd);
    end
  endtask

  // Wh = sum of value times W row; coef = src(a) . Wh(target) + dst(a) . Wh(row)
  task automatic check_reference();
    int acc [`GAT_FEAT_OUT];
    int src;
    int dst;
    int tgt_src;
    int row;
    logic new_sub;
    gat_pkg::wh_vec_t v;
    row = 0;
    tgt_src = 0;
    new_sub = 1'b1;
    foreach (acc[j]) acc[j] = 0;
    for (int n = 0; n < n_nz; n++) begin
      for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
        acc[j] += nz_val[n] * wgt[nz_col[n] * `GAT_FEAT_OUT + j];
      end
      if (nz_rl[n] != 0) begin
        src = 0;
        dst = 0;
        for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
          src += wgt[A_BASE + j] * acc[j];
          dst += wgt[A_BASE + `GAT_FEAT_OUT + j] * acc[j];
          v[j] = gat_pkg::wh_t'(acc[j]);
          acc[j] = 0;
        end
        if (new_sub) begin
          tgt_src = src;
        end
        new_sub = (nz_sl[n] != 0);
        if (row >= n_rows) begin
          report_error("nonzero list holds more rows than the file's Wh rows");
        end else begin
          if (v !== file_wh[row]) begin
            report_error($sformatf("file Wh row %0d disagrees with the reference", row));
          end
          if (gat_pkg::coef_t'(tgt_src + dst) !== file_coef[row]) begin
            report_error($sformatf("file coefficient %0d disagrees with the reference", row));
          end
          if (file_last[row] !== new_sub) begin
            report_error($sformatf("file last flag %0d disagrees with the nonzero list", row));
          end
        end
        row++;
      end
    end
    if (row != n_rows) begin
      report_error("row count in the file does not match the nonzero list");
    end
  endtask

  task automatic load_weights();
    for (int i = 0; i < `GAT_WGT_DEPTH; i++) begin
      wgt_wr = 1'b1;
      wgt_addr = `GAT_WGT_ADDR_W'(i);
      wgt_data = gat_pkg::data_t'(wgt[i]);
      step_cycle();
    end
    wgt_wr = 1'b0;
    check_flag("gat_ready_o before done", 1'b0, gat_ready);
    wgt_done = 1'b1;
    step_cycle();
    wgt_done = 1'b0;
    check_flag("gat_ready_o after done", 1'b1, gat_ready);
  endtask

  task automatic send_rows();
    int row;
    row = 0;
    for (int n = 0; n < n_nz; n++) begin
      h_vld = 1'b1;
      h_col = gat_pkg::col_t'(nz_col[n]);
      h_val = gat_pkg::data_t'(nz_val[n]);
      h_row_last = (nz_rl[n] != 0);
      h_sub_last = (nz_sl[n] != 0);
      if (nz_rl[n] != 0) begin
        // Row leaves one cycle after the accepting edge
        wh_exp_q.push_back(file_wh[row]);
        wh_cyc_q.push_back(cycle + 1);
        row++;
      end
      step_cycle();
    end
    h_vld = 1'b0;
    h_row_last = 1'b0;
    h_sub_last = 1'b0;
  endtask

  task automatic read_coefs();
    int idx;
    int e0;
    string name;
    idx = 0;
    while (coef_empty) begin
      step_cycle();
    end
    // Long stall while the first subgraph queues up
    repeat (30) step_cycle();
    while (idx < n_rows) begin
      if (!coef_empty && (($urandom % 4) != 0)) begin
        name = $sformatf("coef%0d", idx);
        e0 = errors;
        check_coef(name, file_coef[idx], coef);
        check_flag({name, " last"}, file_last[idx], coef_last);
        finish_test(name, e0);
        coef_rd = 1'b1;
        idx++;
      end else begin
        coef_rd = 1'b0;
      end
      step_cycle();
    end
    coef_rd = 1'b0;
  endtask

  task automatic check_wh_row();
    int e0;
    int exp_cyc;
    gat_pkg::wh_vec_t exp_v;
    string name;
    e0 = errors;
    name = $sformatf("wh_row%0d", wh_idx);
    if (wh_exp_q.size() == 0) begin
      report_error("wh_vld_o pulsed with no row pending");
    end else begin
      exp_v = wh_exp_q.pop_front();
      exp_cyc = wh_cyc_q.pop_front();
      check_wh(name, exp_v, wh);
      if (cycle != exp_cyc) begin
        errors++;
        $display("FAIL %s expected cycle %0d actual cycle %0d", name, exp_cyc, cycle);
      end
      finish_test(name, e0);
      wh_idx++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n && wh_vld) begin
      check_wh_row();
    end
  end

  task automatic run_tests();
    int e0;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;
    e0 = errors;
    check_flag("reset coef_empty_o", 1'b1, coef_empty);
    check_flag("reset gat_ready_o", 1'b0, gat_ready);
    check_flag("reset wh_vld_o", 1'b0, wh_vld);
    // Strobe before the load must be dropped
    h_vld = 1'b1;
    h_row_last = 1'b1;
    step_cycle();
    h_vld = 1'b0;
    h_row_last = 1'b0;
    repeat (2) step_cycle();
    finish_test("reset_state", e0);
    e0 = errors;
    load_weights();
    finish_test("weight_load", e0);
    fork
      send_rows();
      read_coefs();
    join
    repeat (4) step_cycle();
    e0 = errors;
    check_flag("drain coef_empty_o", 1'b1, coef_empty);
    if (wh_exp_q.size() != 0) begin
      report_error("some Wh rows never appeared on wh_o");
    end
    finish_test("drain", e0);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    wgt_wr = 1'b0;
    wgt_addr = '0;
    wgt_data = '0;
    wgt_done = 1'b0;
    h_vld = 1'b0;
    h_col = '0;
    h_val = '0;
    h_row_last = 1'b0;
    h_sub_last = 1'b0;
    coef_rd = 1'b0;
    void'($urandom(12));
    read_stimulus();
    check_reference();
    limit = 4 * (n_nz + n_rows) + 200;
    if (errors == 0) begin
      run_tests();
    end
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: gat_stimulus.txt
# 40 weight bytes: W row-major (feature, out column), then a; nonzeros: col value row_last sub_last
# Then the Wh row count, Wh rows as four out columns, and coefficients as: value last
1 2 -1 3 0 -2 4 1
5 1 0 -3 -1 -1 2 2
3 0 1 -2 2 4 -3 0
-4 1 1 1 1 -1 0 5
1 -2 0 1 2 1 -1 -1
16
0 2 0 0
3 -1 1 0
1 3 1 0
2 -2 0 0
5 1 0 0
7 4 1 1
4 -5 0 0
6 2 1 1
4 127 0 0
7 -3 1 0
0 1 0 0
1 1 0 0
2 1 0 0
3 1 1 0
5 -1 0 0
6 3 1 1
7
3 5 -4 4
0 -6 12 3
-4 -2 -3 26
-23 2 -3 12
378 3 127 -269
5 0 5 3
-14 -1 6 3
8 0
-24 0
-36 1
-68 1
1004 0
105 0
65 1

// File: build.f
+incdir+.
gat_pkg.sv
gat_weight_bank.sv
gat_fifo.sv
gat_wh_accum.sv
gat_coef_calc.sv
gat_conv_top.sv
tb_gat_conv.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_gat_conv
FILELIST  = build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
